// ==== rtl/sm83_pkg.sv ====
`default_nettype none

package sm83_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  step_t;    // Microcode step within one instruction

    // 8-bit register slots, MEM selects the external data bus
    typedef enum logic [3:0] {
        NONE = 4'd0,
        Z    = 4'd1,
        W    = 4'd2,
        B    = 4'd3,
        C    = 4'd4,
        D    = 4'd5,
        E    = 4'd6,
        H    = 4'd7,
        L    = 4'd8,
        PCH  = 4'd9,
        PCL  = 4'd10,
        A    = 4'd11,
        MEM  = 4'd15
    } reg8_t;

    typedef enum logic [1:0] {
        WZ,
        HL,
        PC
    } reg16_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef enum logic [1:0] {
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C
    } cond_t;

    // Order follows opcode bits 5..3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    typedef enum logic {ACC_A, ACC_DB} acc_sel_t;
    typedef enum logic {ARG_DB, ARG_ONE} arg_sel_t;
    typedef enum logic {WB_DB, WB_ALU} wb_sel_t;

    // Memory map
    localparam addr_t HRAM_BASE  = 16'hff80;
    localparam int    HRAM_DEPTH = 128;

    // Opcode groups, ? bits are don't care in the decoder table
    localparam byte_t OP_NOP      = 8'b0000_0000;
    localparam byte_t OP_LD_R_N   = 8'b00??_?110;
    localparam byte_t OP_INCDEC_R = 8'b00??_?10?;  // Bit 0 selects DEC
    localparam byte_t OP_LD_R_R   = 8'b01??_????;
    localparam byte_t OP_ALU_A_R  = 8'b10??_????;
    localparam byte_t OP_ALU_A_N  = 8'b11??_?110;
    localparam byte_t OP_JP_NN    = 8'b1100_0011;
    localparam byte_t OP_JP_CC_NN = 8'b110?_?010;
    localparam byte_t OP_LD_A_NN  = 8'b1111_1010;
    localparam byte_t OP_LD_NN_A  = 8'b1110_1010;

endpackage

`default_nettype wire

// ==== rtl/sm83_ctrl_if.sv ====
`default_nettype none

// Decoded control word for one machine step
interface sm83_ctrl_if;
    import sm83_pkg::*;

    reg16_t   s_ab;         // Address bus source
    reg8_t    s_db;         // Data bus source
    reg8_t    t_db;         // Data bus target
    wb_sel_t  wb_sel;
    acc_sel_t acc_sel;
    arg_sel_t arg_sel;
    alu_op_t  alu_op;
    logic     wr_pc;        // PC <- incremented address
    logic     load_pc_wz;   // PC <- WZ

    modport decoder_mp (
        output s_ab, s_db, t_db, wb_sel, acc_sel, arg_sel, alu_op, wr_pc, load_pc_wz
    );

    modport datapath_mp (
        input s_ab, s_db, t_db, wb_sel, acc_sel, arg_sel, alu_op, wr_pc, load_pc_wz
    );

endinterface

`default_nettype wire

// ==== rtl/sm83_alu.sv ====
`default_nettype none

module sm83_alu (
    input  sm83_pkg::alu_op_t op,
    input  sm83_pkg::byte_t   acc,
    input  sm83_pkg::byte_t   arg,
    input  logic              c_in,
    output sm83_pkg::byte_t   res,
    output sm83_pkg::flags_t  f_out
);
    import sm83_pkg::*;

    byte_t added;   // Argument, inverted for subtraction
    byte_t sum;
    logic  carry;
    logic  half;
    logic  c_out;
    logic  sub;

    assign sub = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);

    always_comb begin
        added = sub ? ~arg : arg;
        case (op)
            ALU_ADC, ALU_SBC: carry = c_in;
            ALU_SUB, ALU_CP:  carry = 1'b1;    // Two's complement plus one
            default:          carry = 1'b0;
        endcase
    end

    // Nibble split gives the half carry
    assign {half, sum[3:0]}  = {1'b0, acc[3:0]} + {1'b0, added[3:0]} + {4'd0, carry};
    assign {c_out, sum[7:4]} = {1'b0, acc[7:4]} + {1'b0, added[7:4]} + {4'd0, half};

    always_comb begin
        case (op)
            ALU_AND: res = acc & arg;
            ALU_XOR: res = acc ^ arg;
            ALU_OR:  res = acc | arg;
            default: res = sum;     // CP result is dropped by the datapath
        endcase
        f_out.z = (res == 8'h00);
        if (op == ALU_AND || op == ALU_XOR || op == ALU_OR) begin
            f_out.n = 1'b0;
            f_out.h = 1'b0;
            f_out.c = 1'b0;
        end else begin
            f_out.n = sub;
            f_out.h = half;
            f_out.c = c_out;    // Set on no borrow for subtraction
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sm83_sequencer.sv ====
`default_nettype none

module sm83_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             ce,
    input  sm83_pkg::byte_t  d_in,
    input  logic             done,
    input  logic             is_cond,
    input  sm83_pkg::cond_t  cond,
    input  sm83_pkg::step_t  next_step,
    input  sm83_pkg::flags_t flags,
    output sm83_pkg::byte_t  ir,
    output sm83_pkg::step_t  step
);
    import sm83_pkg::*;

    logic taken;    // Condition holds

    always_comb begin
        case (cond)
            COND_NZ: taken = !flags.z;
            COND_Z:  taken = flags.z;
            COND_NC: taken = !flags.c;
            default: taken = flags.c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ir   <= OP_NOP;     // First step fetches from address 0
            step <= '0;
        end else if (ce) begin
            if (done) begin
                ir   <= d_in;
                step <= '0;
            end else if (is_cond && !taken) begin
                step <= next_step;  // Skip the taken-branch steps
            end else begin
                step <= step + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sm83_decoder.sv ====
`default_nettype none

module sm83_decoder (
    input  sm83_pkg::byte_t ir,
    input  sm83_pkg::step_t step,
    output logic            done,
    output logic            is_cond,
    output sm83_pkg::cond_t cond,
    output sm83_pkg::step_t next_step,
    sm83_ctrl_if.decoder_mp ctrl
);
    import sm83_pkg::*;

    reg8_t r_dst;   // Field in bits 5..3
    reg8_t r_src;   // Field in bits 2..0
    logic  fetch;   // Final step, opcode read at PC

    function automatic reg8_t r8_decode(input logic [2:0] field);
        case (field)
            3'd0: r8_decode = B;
            3'd1: r8_decode = C;
            3'd2: r8_decode = D;
            3'd3: r8_decode = E;
            3'd4: r8_decode = H;
            3'd5: r8_decode = L;
            3'd7: r8_decode = A;
            default: r8_decode = NONE;   // (HL) operand is not supported
        endcase
    endfunction

    assign r_dst = r8_decode(ir[5:3]);
    assign r_src = r8_decode(ir[2:0]);
    assign cond  = cond_t'(ir[4:3]);

    always_comb begin
        fetch           = 1'b0;
        is_cond         = 1'b0;
        next_step       = '0;
        ctrl.s_ab       = PC;
        ctrl.s_db       = NONE;
        ctrl.t_db       = NONE;
        ctrl.wb_sel     = WB_DB;
        ctrl.acc_sel    = ACC_A;
        ctrl.arg_sel    = ARG_DB;
        ctrl.alu_op     = alu_op_t'(ir[5:3]);
        ctrl.wr_pc      = 1'b0;
        ctrl.load_pc_wz = 1'b0;

        casez ({ir, step})
            {OP_NOP, 3'd0}: fetch = 1'b1;

            // z <- [pc]; pc++
            {OP_LD_R_N, 3'd0}, {OP_ALU_A_N, 3'd0}, {OP_JP_NN, 3'd0},
            {OP_JP_CC_NN, 3'd0}, {OP_LD_A_NN, 3'd0}, {OP_LD_NN_A, 3'd0}: begin
                ctrl.wr_pc = 1'b1;
                ctrl.s_db  = MEM;
                ctrl.t_db  = Z;
            end

            // w <- [pc]; pc++
            {OP_JP_NN, 3'd1}, {OP_LD_A_NN, 3'd1}, {OP_LD_NN_A, 3'd1}: begin
                ctrl.wr_pc = 1'b1;
                ctrl.s_db  = MEM;
                ctrl.t_db  = W;
            end

            {OP_LD_R_N, 3'd1}: begin
                fetch     = 1'b1;
                ctrl.s_db = Z;
                ctrl.t_db = r_dst;
            end

            {OP_ALU_A_N, 3'd1}: begin
                fetch       = 1'b1;
                ctrl.s_db   = Z;
                ctrl.t_db   = A;
                ctrl.wb_sel = WB_ALU;
            end

            {OP_INCDEC_R, 3'd0}: begin  // r <- r +/- 1
                fetch        = 1'b1;
                ctrl.s_db    = r_dst;
                ctrl.t_db    = r_dst;
                ctrl.wb_sel  = WB_ALU;
                ctrl.acc_sel = ACC_DB;
                ctrl.arg_sel = ARG_ONE;
                ctrl.alu_op  = ir[0] ? ALU_SUB : ALU_ADD;
            end

            {OP_LD_R_R, 3'd0}: begin
                fetch     = 1'b1;
                ctrl.s_db = r_src;
                ctrl.t_db = r_dst;
            end

            {OP_ALU_A_R, 3'd0}: begin
                fetch       = 1'b1;
                ctrl.s_db   = r_src;
                ctrl.t_db   = A;
                ctrl.wb_sel = WB_ALU;
            end

            {OP_JP_CC_NN, 3'd1}: begin  // Falls through to step 3 when cc fails
                ctrl.wr_pc = 1'b1;
                ctrl.s_db  = MEM;
                ctrl.t_db  = W;
                is_cond    = 1'b1;
                next_step  = 3'd3;
            end

            // Bus idles on PC while the target loads
            {OP_JP_NN, 3'd2}, {OP_JP_CC_NN, 3'd2}: ctrl.load_pc_wz = 1'b1;

            {OP_LD_A_NN, 3'd2}: begin   // a <- [wz]
                ctrl.s_ab = WZ;
                ctrl.s_db = MEM;
                ctrl.t_db = A;
            end

            {OP_LD_NN_A, 3'd2}: begin   // [wz] <- a
                ctrl.s_ab = WZ;
                ctrl.s_db = A;
                ctrl.t_db = MEM;
            end

            {OP_JP_NN, 3'd3}, {OP_JP_CC_NN, 3'd3},
            {OP_LD_A_NN, 3'd3}, {OP_LD_NN_A, 3'd3}: fetch = 1'b1;

            default: fetch = 1'b1;      // Unused opcodes act as NOP
        endcase

        done = fetch;
        if (fetch) begin
            ctrl.wr_pc = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sm83_datapath.sv ====
`default_nettype none

module sm83_datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              ce,
    sm83_ctrl_if.datapath_mp  ctrl,
    input  sm83_pkg::alu_op_t alu_op,
    input  sm83_pkg::byte_t   rd_data,
    output sm83_pkg::addr_t   addr,
    output sm83_pkg::byte_t   wr_data,
    output logic              write,
    output sm83_pkg::flags_t  flags
);
    import sm83_pkg::*;

    byte_t  rf [Z:A];   // Z, W, B..L, PCH, PCL, A
    addr_t  ab;
    addr_t  pc_inc;
    byte_t  db;
    byte_t  acc;
    byte_t  arg;
    byte_t  alu_res;
    byte_t  r_wb;
    flags_t alu_flags;
    logic   rf_we;

    always_comb begin
        case (ctrl.s_ab)
            WZ:      ab = {rf[W], rf[Z]};
            default: ab = {rf[PCH], rf[PCL]};
        endcase
        case (ctrl.s_db)
            NONE:    db = 8'h00;
            MEM:     db = rd_data;
            default: db = rf[ctrl.s_db];
        endcase
    end

    assign addr    = rst ? ab : 16'h0000;  // Bus parked at 0 in reset
    assign write   = rst && (ctrl.t_db == MEM);
    assign wr_data = db;
    assign pc_inc  = ab + 16'd1;

    assign acc = (ctrl.acc_sel == ACC_DB) ? db : rf[A];
    assign arg = (ctrl.arg_sel == ARG_ONE) ? 8'd1 : db;

    sm83_alu alu (
        .op   (alu_op),
        .acc  (acc),
        .arg  (arg),
        .c_in (flags.c),
        .res  (alu_res),
        .f_out(alu_flags)
    );

    assign r_wb  = (ctrl.wb_sel == WB_ALU) ? alu_res : db;
    // CP only updates flags
    assign rf_we = (ctrl.t_db != NONE) && (ctrl.t_db != MEM)
                   && !(ctrl.wb_sel == WB_ALU && ctrl.alu_op == ALU_CP);

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = Z; i <= A; i++) begin
                rf[i] <= 8'h00;
            end
            flags <= '0;
        end else if (ce) begin
            if (rf_we) begin
                rf[ctrl.t_db] <= r_wb;
            end
            if (ctrl.wr_pc) begin
                {rf[PCH], rf[PCL]} <= pc_inc;
            end else if (ctrl.load_pc_wz) begin
                {rf[PCH], rf[PCL]} <= {rf[W], rf[Z]};  // Jump target
            end
            if (ctrl.wb_sel == WB_ALU) begin
                flags <= alu_flags;     // INC/DEC touch carry too
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sm83_mem_map.sv ====
`default_nettype none

module sm83_mem_map (
    input  logic            clk,
    input  logic            ce,
    input  sm83_pkg::addr_t addr,
    input  logic            write,
    input  sm83_pkg::byte_t wr_data,
    input  sm83_pkg::byte_t d_in_ext,
    output sm83_pkg::byte_t rd_data
);
    import sm83_pkg::*;

    byte_t                           hram [HRAM_DEPTH];
    logic                            in_hram;
    logic [$clog2(HRAM_DEPTH)-1:0]   hram_idx;

    // High RAM sits at the top of the address space
    assign in_hram  = (addr >= HRAM_BASE);
    assign hram_idx = addr[$clog2(HRAM_DEPTH)-1:0];

    // High RAM answers in place of the external bus
    assign rd_data = in_hram ? hram[hram_idx] : d_in_ext;

    always_ff @(posedge clk) begin
        if (ce && write && in_hram) begin
            hram[hram_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sm83_core.sv ====
`default_nettype none

module sm83_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            ce,
    output sm83_pkg::addr_t addr,
    input  sm83_pkg::byte_t d_in_ext,
    output sm83_pkg::byte_t d_out,
    output logic            write
);
    import sm83_pkg::*;

    byte_t  ir;
    byte_t  rd_data;    // After the high RAM decode
    step_t  step;
    step_t  next_step;
    logic   done;
    logic   is_cond;
    cond_t  cond;
    flags_t flags;

    sm83_ctrl_if ctrl_bus ();

    sm83_sequencer seq (
        .clk      (clk),
        .rst      (rst),
        .ce       (ce),
        .d_in     (rd_data),
        .done     (done),
        .is_cond  (is_cond),
        .cond     (cond),
        .next_step(next_step),
        .flags    (flags),
        .ir       (ir),
        .step     (step)
    );

    sm83_decoder dec (
        .ir       (ir),
        .step     (step),
        .done     (done),
        .is_cond  (is_cond),
        .cond     (cond),
        .next_step(next_step),
        .ctrl     (ctrl_bus.decoder_mp)
    );

    sm83_datapath dp (
        .clk    (clk),
        .rst    (rst),
        .ce     (ce),
        .ctrl   (ctrl_bus.datapath_mp),
        .alu_op (ctrl_bus.alu_op),
        .rd_data(rd_data),
        .addr   (addr),
        .wr_data(d_out),
        .write  (write),
        .flags  (flags)
    );

    sm83_mem_map mem_map (
        .clk     (clk),
        .ce      (ce),
        .addr    (addr),
        .write   (write),
        .wr_data (d_out),
        .d_in_ext(d_in_ext),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== bench/sm83_assertions.sv ====
`default_nettype none

module sm83_assertions (
    input logic            clk,
    input logic            rst,
    input logic            ce,
    input sm83_pkg::addr_t addr,
    input logic            write
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;    // Number of failed assertions

    // No stores while the core is held in reset
    write_low_in_reset: assert property (@(posedge clk) !rst |-> !write)
        else begin
            $error("write is high while rst is low");
            fail_count++;
        end

    bus_holds_without_ce: assert property (
        @(posedge clk) disable iff (!rst) !ce |=> ($stable(addr) && $stable(write))
    ) else begin
        $error("addr or write moved across a cycle with ce low");
        fail_count++;
    end

    // A store step is always followed by a fetch
    no_back_to_back_store: assert property (
        @(posedge clk) disable iff (!rst) (write && ce) |=> !write
    ) else begin
        $error("write high in two ce cycles in a row");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== bench/sm83_tb.sv ====
`default_nettype none

module sm83_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sm83_pkg::*;

    localparam int  NUM_INSTR   = 500;
    localparam time WATCHDOG_NS = NUM_INSTR * 4 * 8 * 2 + 2000;

    logic   clk;
    logic   rst;
    logic   ce;
    addr_t  addr;
    byte_t  d_in_ext;
    byte_t  d_out;
    logic   write;

    byte_t  mem [0:65535];      // External bus memory for program and data
    int     seed = 32'h255a;

    // Instruction-level model state
    byte_t  m_reg [0:7];        // Indexed by the opcode register field
    flags_t m_flags;
    addr_t  m_pc;
    byte_t  m_hram [0:127];
    logic   hram_ok [0:127];

    // Expected bus activity per ce cycle
    addr_t  exp_addr [$];
    logic   exp_wr [$];
    byte_t  exp_data [$];
    flags_t exp_flg [$];

    sm83_core uut (
        .clk     (clk),
        .rst     (rst),
        .ce      (ce),
        .addr    (addr),
        .d_in_ext(d_in_ext),
        .d_out   (d_out),
        .write   (write)
    );

    bind sm83_core sm83_assertions asrt (
        .clk  (clk),
        .rst  (rst),
        .ce   (ce),
        .addr (addr),
        .write(write)
    );

    assign d_in_ext = mem[addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rnd(input int n);
        rnd = ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [2:0] pick_reg();   // Any field but 6
        logic [2:0] f;
        f = 3'(rnd(7));
        pick_reg = (f == 3'd6) ? 3'd7 : f;
    endfunction

    // Result from the flag rules, also updates the model flags
    function automatic byte_t alu_model(input alu_op_t op, input byte_t a, input byte_t b);
        logic       sub;
        logic       cin;
        byte_t      bb;
        logic [4:0] lo;
        logic [8:0] full;
        sub  = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
        bb   = sub ? ~b : b;
        cin  = (op == ALU_ADC || op == ALU_SBC) ? m_flags.c : sub;
        lo   = a[3:0] + bb[3:0] + cin;
        full = a + bb + cin;
        case (op)
            ALU_AND: alu_model = a & b;
            ALU_XOR: alu_model = a ^ b;
            ALU_OR:  alu_model = a | b;
            default: alu_model = full[7:0];
        endcase
        m_flags.z = (alu_model == 8'h00);
        m_flags.n = sub;
        m_flags.h = (op == ALU_AND || op == ALU_XOR || op == ALU_OR) ? 1'b0 : lo[4];
        m_flags.c = (op == ALU_AND || op == ALU_XOR || op == ALU_OR) ? 1'b0 : full[8];
    endfunction

    task automatic push(input addr_t a, input logic w, input byte_t d, input flags_t f);
        exp_addr.push_back(a);
        exp_wr.push_back(w);
        exp_data.push_back(d);
        exp_flg.push_back(f);
    endtask

    task automatic fetch_next(input flags_t f);     // Last step latches the opcode
        push(m_pc, 1'b0, 8'h00, f);
        m_pc = m_pc + 16'd1;
    endtask

    // Lays out a random program while the model runs it
    task automatic build_program();
        addr_t      p;
        addr_t      nn;
        addr_t      tgt;
        flags_t     f0;
        logic [2:0] d;
        logic [2:0] s;
        logic [2:0] op;
        logic [1:0] cc;
        logic       taken;
        logic       dec;
        logic       force_store;
        int         kind;
        byte_t      res;
        force_store = 1'b0;
        push(16'h0000, 1'b0, 8'h00, '0);        // Reset IR holds NOP
        m_pc = 16'h0001;
        for (int i = 0; i < NUM_INSTR; i++) begin
            p    = m_pc - 16'd1;
            f0   = m_flags;
            kind = force_store ? 9 : rnd(10);
            force_store = 1'b0;
            d    = pick_reg();
            s    = pick_reg();
            op   = 3'(rnd(8));
            case (kind)
                1, 4: begin     // LD r,n and ALU A,n
                    mem[p] = (kind == 1) ? {2'b00, d, 3'b110} : {2'b11, op, 3'b110};
                    mem[m_pc] = 8'(rnd(256));
                    push(m_pc, 1'b0, 8'h00, f0);
                    if (kind == 1) begin
                        m_reg[d] = mem[m_pc];
                    end else begin
                        res = alu_model(alu_op_t'(op), m_reg[7], mem[m_pc]);
                        if (op != 3'd7) m_reg[7] = res;
                        force_store = 1'b1;
                    end
                    m_pc = m_pc + 16'd1;
                    fetch_next(f0);
                end
                2: begin
                    mem[p]   = {2'b01, d, s};
                    m_reg[d] = m_reg[s];
                    fetch_next(f0);
                end
                3: begin
                    mem[p] = {2'b10, op, s};
                    res    = alu_model(alu_op_t'(op), m_reg[7], m_reg[s]);
                    if (op != 3'd7) m_reg[7] = res;    // CP keeps A
                    force_store = 1'b1;
                    fetch_next(f0);
                end
                5: begin
                    dec      = 1'(rnd(2));
                    mem[p]   = {2'b00, d, 2'b10, dec};
                    m_reg[d] = alu_model(dec ? ALU_SUB : ALU_ADD, m_reg[d], 8'd1);
                    force_store = 1'b1;
                    fetch_next(f0);
                end
                6, 7: begin
                    cc  = 2'(rnd(4));
                    tgt = m_pc + 16'd2 + 16'(rnd(16));  // Forward only
                    mem[p] = (kind == 6) ? 8'hc3 : {3'b110, cc, 3'b010};
                    mem[m_pc]         = tgt[7:0];
                    mem[m_pc + 16'd1] = tgt[15:8];
                    push(m_pc, 1'b0, 8'h00, f0);
                    push(m_pc + 16'd1, 1'b0, 8'h00, f0);
                    case (cc)
                        2'd0:    taken = !m_flags.z;
                        2'd1:    taken = m_flags.z;
                        2'd2:    taken = !m_flags.c;
                        default: taken = m_flags.c;
                    endcase
                    if (kind == 6 || taken) begin
                        push(m_pc + 16'd2, 1'b0, 8'h00, f0);
                        m_pc = tgt;
                    end else begin
                        m_pc = m_pc + 16'd2;
                    end
                    fetch_next(f0);
                end
                8, 9: begin
                    nn = 16'hc000 + 16'(rnd(256));
                    if (rnd(2) == 1) begin
                        nn = 16'hff80 + 16'(rnd(127));
                        // A high RAM load needs a stored byte unlike the bus byte
                        if (kind == 8 && (!hram_ok[nn[6:0]]
                                          || mem[nn] == m_hram[nn[6:0]])) begin
                            nn = 16'hc000 + 16'(rnd(256));
                        end
                    end
                    mem[p] = (kind == 8) ? 8'hfa : 8'hea;
                    mem[m_pc]         = nn[7:0];
                    mem[m_pc + 16'd1] = nn[15:8];
                    push(m_pc, 1'b0, 8'h00, f0);
                    push(m_pc + 16'd1, 1'b0, 8'h00, f0);
                    if (kind == 9) begin
                        push(nn, 1'b1, m_reg[7], f0);
                        if (nn >= 16'hff80) begin
                            m_hram[nn[6:0]]  = m_reg[7];
                            hram_ok[nn[6:0]] = 1'b1;
                        end
                    end else begin
                        push(nn, 1'b0, 8'h00, f0);
                        if (nn >= 16'hff80) begin
                            m_reg[7] = m_hram[nn[6:0]];
                        end else begin
                            m_reg[7] = mem[nn];
                        end
                    end
                    m_pc = m_pc + 16'd2;
                    fetch_next(f0);
                end
                default: begin
                    mem[p] = 8'h00;
                    fetch_next(f0);
                end
            endcase
        end
    endtask

    task automatic fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) fail($sformatf("addr %h, expected %h", got, exp));
    endtask

    task automatic check_write(input logic got, input logic exp);
        if (got !== exp) fail($sformatf("write %b, expected %b", got, exp));
    endtask

    task automatic check_data(input byte_t got, input byte_t exp);
        if (got !== exp) fail($sformatf("d_out %h, expected %h", got, exp));
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp);
        if (got !== exp) fail($sformatf("flags %b, expected %b", got, exp));
    endtask

    initial begin
        rst     = 1'b0;
        ce      = 1'b0;
        m_flags = '0;
        for (int a = 0; a < 65536; a++) mem[a] = 8'($random(seed));
        for (int r = 0; r < 8; r++) m_reg[r] = 8'h00;
        for (int h = 0; h < 128; h++) begin
            m_hram[h]  = 8'h00;
            hram_ok[h] = 1'b0;
        end
        build_program();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        ce  <= 1'b1;
        while (exp_addr.size() > 0) begin
            @(posedge clk);
            if (ce) begin
                check_addr(addr, exp_addr.pop_front());
                check_write(write, exp_wr[0]);
                if (exp_wr[0]) check_data(d_out, exp_data[0]);
                check_flags(uut.flags, exp_flg.pop_front());
                void'(exp_wr.pop_front());
                void'(exp_data.pop_front());
            end
            ce <= (rnd(4) != 0);    // About 75% high
        end
        if (uut.asrt.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d bus protocol assertions failed", uut.asrt.fail_count);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not finish in time");
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== sm83_core.f ====
rtl/sm83_pkg.sv
rtl/sm83_ctrl_if.sv
rtl/sm83_alu.sv
rtl/sm83_sequencer.sv
rtl/sm83_decoder.sv
rtl/sm83_datapath.sv
rtl/sm83_mem_map.sv
rtl/sm83_core.sv
bench/sm83_assertions.sv
bench/sm83_tb.sv

// ==== Bender.yml ====
package:
  name: sm83_core

sources:
  - rtl/sm83_pkg.sv
  - rtl/sm83_ctrl_if.sv
  - rtl/sm83_alu.sv
  - rtl/sm83_sequencer.sv
  - rtl/sm83_decoder.sv
  - rtl/sm83_datapath.sv
  - rtl/sm83_mem_map.sv
  - rtl/sm83_core.sv
  - target: test
    files:
      - bench/sm83_assertions.sv
      - bench/sm83_tb.sv
